// File: test/pmaVectors.txt
// Columns: address access clear expSelect expAttr expFault, all hex
// access = {read, write, execute, atomic, size[2:0]}, attr = {cache, idem, amo}, fault = {i, l, s}
00C000000 42 0 01 0 0
00C000010 22 0 01 0 0
00FFFFFFC 42 0 01 0 0
010000000 40 0 02 0 0
010000007 20 0 02 0 0
010060000 42 0 04 0 0
0100600FC 22 0 04 0 0
002000000 43 0 08 0 0
00200BFF8 22 0 08 0 0
080000000 12 0 10 7 0
080001000 40 0 10 7 0
087FFFFFE 21 0 10 7 0
000001000 12 0 20 4 0
000001FF8 43 0 20 4 0
080000000 02 0 00 0 0
040000000 42 0 00 0 2
040000000 22 0 00 0 1
100001000 12 0 00 0 4
200000000 42 0 00 0 2
080000000 42 1 10 7 0
000002000 12 0 00 0 4
010060000 40 0 00 0 2
010000000 42 1 00 0 2
000001000 22 1 00 0 1
080000000 42 1 10 7 0
002000000 40 0 00 0 2
002000000 44 1 00 0 2
080000100 0A 1 10 7 0
080000200 0B 0 10 7 0
002004000 0A 0 08 0 1
00C000000 0A 0 01 0 1
000001000 0A 0 00 0 1
001000000 6A 1 00 0 3
080000000 72 1 10 7 0
010000008 40 0 00 0 2
010060100 22 0 00 0 1
080000000 42 1 10 7 0
088000000 12 0 00 0 4
0BFFFFFFF 40 0 00 0 2
000000FFF 40 1 00 0 2
000000000 02 1 00 0 0
080000000 42 0 10 7 0

// File: pmaUnit.f
source/pmaPkg.sv
source/adrDec.sv
source/adrDecs.sv
source/pmaChecker.sv
source/faultRecorder.sv
source/pmaUnit.sv
test/pmaUnit_asserts.sv
test/pmaUnitTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the PMA unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module pmaUnitTb -f pmaUnit.f -o simPmaUnit

# Keep running past assertion errors so the testbench prints its own verdict
./obj_dir/simPmaUnit +verilator+error+limit+1000 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: test/pmaUnitTb.sv
module pmaUnitTb;
  import pmaPkg::*;

  // A 34 bit address leaves two bits above the 32 bit map to exercise
  localparam int PaBits       = 34;
  localparam int ClkPeriod    = 20;
  localparam int ResetCycles  = 8;
  localparam int NumVecs      = 42;
  localparam int FieldsPerVec = 6;
  localparam int NumRandom    = 40;
  // Reset, file vectors, random vectors and one final idle cycle plus a margin
  localparam int CycleLimit   = ResetCycles + NumVecs + NumRandom + 1 + 50;

  localparam logic [31:0] RandSeed = 32'h9df4_c1ed;

  logic                  clk;
  logic                  rst;
  logic [PaBits-1:0]     physAddr;
  pmaAccessT             access;
  logic                  faultClear;
  logic [NumRegions-1:0] hselRegions;
  pmaAttrT               attr;
  pmaFaultT              fault;
  logic                  squashBusAccess;
  logic                  faultValid;
  logic [PaBits-1:0]     faultAddr;
  pmaFaultT              faultCause;

  // Each access takes six hex fields of one memory word each
  logic [35:0] vecMem [NumVecs*FieldsPerVec];

  int errorCount = 0;
  int cycleCount = 0;

  // Expected state of the fault recorder
  logic              modelValid;
  logic [PaBits-1:0] modelAddr;
  pmaFaultT          modelCause;

  pmaUnit #(
    .PaBits (PaBits)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .physAddr        (physAddr),
    .access          (access),
    .faultClear      (faultClear),
    .hselRegions     (hselRegions),
    .attr            (attr),
    .fault           (fault),
    .squashBusAccess (squashBusAccess),
    .faultValid      (faultValid),
    .faultAddr       (faultAddr),
    .faultCause      (faultCause)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // The watchdog ends a run that outlasts the stimulus by too much
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkRecorder();
    checkValue("faultValid", 64'(faultValid), 64'(modelValid));
    checkValue("faultAddr", 64'(faultAddr), 64'(modelAddr));
    checkValue("faultCause", 64'(faultCause), 64'(modelCause));
  endtask

  // The edge at the end of the access cycle applies clear before capture
  task automatic predictRecorder(input logic [PaBits-1:0] addr, input logic clr,
                                 input pmaFaultT expFault);
    logic anyFault;
    anyFault = expFault.instrFault | expFault.loadFault | expFault.storeFault;
    if (anyFault && (!modelValid || clr)) begin
      modelValid = 1'b1;
      modelAddr  = addr;
      modelCause = expFault;
    end else if (clr) begin
      modelValid = 1'b0;
    end
  endtask

  // Combinational outputs of each access are stable by the falling edge
  task automatic applyAccess(input logic [PaBits-1:0] addr, input pmaAccessT acc,
                             input logic clr, input logic [NumRegions-1:0] expSel,
                             input pmaAttrT expAttr, input pmaFaultT expFault);
    logic expSquash;
    expSquash = expFault.instrFault | expFault.loadFault | expFault.storeFault;
    @(posedge clk);
    physAddr   <= addr;
    access     <= acc;
    faultClear <= clr;
    @(negedge clk);
    checkValue("hselRegions", 64'(hselRegions), 64'(expSel));
    checkValue("attr", 64'(attr), 64'(expAttr));
    checkValue("fault", 64'(fault), 64'(expFault));
    checkValue("squashBusAccess", 64'(squashBusAccess), 64'(expSquash));
    // Recorder outputs still reflect the edge before this access
    checkRecorder();
    predictRecorder(addr, clr, expFault);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          base;
    int unsigned randWord;
    logic [3:0]  kind;
    int          assertFails;
    modelValid = 1'b0;
    modelAddr  = '0;
    modelCause = '0;
    rst        <= 1'b1;
    physAddr   <= '0;
    access     <= '0;
    faultClear <= 1'b0;
    $readmemh("test/pmaVectors.txt", vecMem);
    void'($urandom(RandSeed));

    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // Recorder must come out of reset empty
    @(negedge clk);
    checkRecorder();

    // Directed accesses from the vector file
    for (int i = 0; i < NumVecs; i++) begin
      base = i * FieldsPerVec;
      applyAccess(vecMem[base][PaBits-1:0], pmaAccessT'(vecMem[base+1][6:0]),
                  vecMem[base+2][0], vecMem[base+3][NumRegions-1:0],
                  pmaAttrT'(vecMem[base+4][2:0]), pmaFaultT'(vecMem[base+5][2:0]));
    end

    // DRAM takes every kind at word size and has all three attributes
    for (int i = 0; i < NumRandom; i++) begin
      randWord = $urandom;
      kind     = 4'($urandom);
      if (kind == 4'd0) begin
        kind = 4'b1000;
      end
      applyAccess(PaBits'(32'h8000_0000 | (randWord & 32'h07FF_FFFC)),
                  pmaAccessT'({kind, 3'd2}), 1'b0, NumRegions'(1 << RegionDram),
                  pmaAttrT'(3'b111), pmaFaultT'(3'b000));
    end

    // A last idle cycle shows the recorder state after the final access
    applyAccess('0, pmaAccessT'(7'h02), 1'b0, '0, pmaAttrT'(3'b000), pmaFaultT'(3'b000));

    assertFails = u_dut.u_asserts.failCount;
    $display("closing: %0d check errors, %0d assertion failures", errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: test/pmaUnit_asserts.sv
module pmaUnitAsserts (
  input logic                          clk,
  input logic                          rst,
  input pmaPkg::pmaAccessT             access,
  input logic [pmaPkg::NumRegions-1:0] hselRegions,
  input pmaPkg::pmaFaultT              fault,
  input logic                          squashBusAccess
);

  // Number of assertion failures so far
  int failCount = 0;

  logic anyFault;

  assign anyFault = fault.instrFault | fault.loadFault | fault.storeFault;

  ////////////////////////////////////////////////////////////////////////////
  // Checker output consistency on the unit clock
  ////////////////////////////////////////////////////////////////////////////

  // The map never overlaps, so at most one region can be selected
  selOneHot : assert property (@(posedge clk) disable iff (rst) $onehot0(hselRegions))
    else begin
      $error("hselRegions has more than one region selected");
      failCount++;
    end

  // Squash is nothing more than the OR of the fault bits
  squashIsAnyFault : assert property (@(posedge clk) disable iff (rst)
    squashBusAccess == anyFault)
    else begin
      $error("squashBusAccess differs from the OR of the fault bits");
      failCount++;
    end

  // Without an atomic the only fault source is a missing region
  faultMeansNoRegion : assert property (@(posedge clk) disable iff (rst)
    (anyFault && !access.atomic) |-> (hselRegions == '0))
    else begin
      $error("a non-atomic fault was raised while a region was selected");
      failCount++;
    end

endmodule

bind pmaUnit pmaUnitAsserts u_asserts (
  .clk             (clk),
  .rst             (rst),
  .access          (access),
  .hselRegions     (hselRegions),
  .fault           (fault),
  .squashBusAccess (squashBusAccess)
);

// File: source/pmaUnit.sv
module pmaUnit #(
  parameter int PaBits = 32
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [PaBits-1:0]             physAddr,
  input  pmaPkg::pmaAccessT             access,
  input  logic                          faultClear,
  output logic [pmaPkg::NumRegions-1:0] hselRegions,
  output pmaPkg::pmaAttrT               attr,
  output pmaPkg::pmaFaultT              fault,
  output logic                          squashBusAccess,
  output logic                          faultValid,
  output logic [PaBits-1:0]             faultAddr,
  output pmaPkg::pmaFaultT              faultCause
);

  ////////////////////////////////////////////////////////////////////////////
  // Combinational checking path
  ////////////////////////////////////////////////////////////////////////////

  // Select, attributes, faults and squash all settle in the access cycle
  pmaChecker #(
    .PaBits (PaBits)
  ) u_pmaChecker (
    .physAddr        (physAddr),
    .access          (access),
    .hselRegions     (hselRegions),
    .attr            (attr),
    .fault           (fault),
    .squashBusAccess (squashBusAccess)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Fault record
  ////////////////////////////////////////////////////////////////////////////

  // The recorder sees the same address the checker decoded this cycle
  faultRecorder #(
    .PaBits (PaBits)
  ) u_faultRecorder (
    .clk        (clk),
    .rst        (rst),
    .fault      (fault),
    .addr       (physAddr),
    .clear      (faultClear),
    .faultValid (faultValid),
    .faultAddr  (faultAddr),
    .faultCause (faultCause)
  );

endmodule

// File: source/faultRecorder.sv
module faultRecorder #(
  parameter int PaBits = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  pmaPkg::pmaFaultT        fault,
  input  logic [PaBits-1:0]       addr,
  input  logic                    clear,
  output logic                    faultValid,
  output logic [PaBits-1:0]       faultAddr,
  output pmaPkg::pmaFaultT        faultCause
);

  logic faultSeen;
  logic captureEn;

  ////////////////////////////////////////////////////////////////////////////
  // Capture rule
  ////////////////////////////////////////////////////////////////////////////

  // Any of the three fault kinds counts as a fault to record
  assign faultSeen = fault.instrFault | fault.loadFault | fault.storeFault;

  // Only the first fault is kept while a record is pending
  // Clear acts first, so a fault in the clear cycle starts a fresh record
  assign captureEn = faultSeen && (!faultValid || clear);

  ////////////////////////////////////////////////////////////////////////////
  // Record registers
  ////////////////////////////////////////////////////////////////////////////

  // The valid flag is set by a capture and dropped by software through clear
  always_ff @(posedge clk) begin
    if (rst) begin
      faultValid <= 1'b0;
    end else if (captureEn) begin
      faultValid <= 1'b1;
    end else if (clear) begin
      faultValid <= 1'b0;
    end
  end

  // Address and cause of the recorded fault
  // They read as zero after reset and keep their last value after a clear,
  // much like a trap-value register that is only rewritten by the next trap
  always_ff @(posedge clk) begin
    if (rst) begin
      faultAddr  <= '0;
      faultCause <= '0;
    end else if (captureEn) begin
      faultAddr  <= addr;
      faultCause <= fault;
    end
  end

endmodule

// File: source/pmaChecker.sv
module pmaChecker #(
  parameter int PaBits = 32
) (
  input  logic [PaBits-1:0]             physAddr,
  input  pmaPkg::pmaAccessT             access,
  output logic [pmaPkg::NumRegions-1:0] hselRegions,
  output pmaPkg::pmaAttrT               attr,
  output pmaPkg::pmaFaultT              fault,
  output logic                          squashBusAccess
);
  import pmaPkg::*;

  logic anyKind;
  logic noRegion;
  logic atomicBlocked;

  // The region decode is purely combinational
  adrDecs #(
    .PaBits (PaBits)
  ) u_adrDecs (
    .addr        (physAddr),
    .access      (access),
    .hselRegions (hselRegions)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Region attributes
  ////////////////////////////////////////////////////////////////////////////

  // Only the memories are cacheable, the peripherals are all uncached
  assign attr.cacheable     = hselRegions[RegionDram] | hselRegions[RegionBootRom];

  // Reads of device registers can have side effects, so only DRAM is idempotent
  assign attr.idempotent    = hselRegions[RegionDram];
  assign attr.atomicAllowed = hselRegions[RegionDram];

  ////////////////////////////////////////////////////////////////////////////
  // Access faults
  ////////////////////////////////////////////////////////////////////////////

  assign anyKind = access.read | access.write | access.execute | access.atomic;

  // An access that no region accepts is a fault of every kind it carries
  assign noRegion = anyKind && !(|hselRegions);

  // An atomic that did select a region still fails where atomics are not allowed
  assign atomicBlocked = access.atomic && (|hselRegions) && !attr.atomicAllowed;

  assign fault.instrFault = access.execute && noRegion;
  assign fault.loadFault  = access.read && noRegion;

  // Atomics report as store faults, as AMO faults do in the privileged spec
  assign fault.storeFault = ((access.write | access.atomic) && noRegion) || atomicBlocked;

  // A faulting access must never reach the bus
  assign squashBusAccess = fault.instrFault | fault.loadFault | fault.storeFault;

endmodule

// File: source/adrDecs.sv
module adrDecs #(
  parameter int PaBits = 32
) (
  input  logic [PaBits-1:0]           addr,
  input  pmaPkg::pmaAccessT           access,
  output logic [pmaPkg::NumRegions-1:0] hselRegions
);
  import pmaPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // One decoder per region of the fixed map
  ////////////////////////////////////////////////////////////////////////////

  // Each decoder gets its base, range, rights and sizes from the package table
  // Bit i of hselRegions belongs to region index i, e.g. bit 4 is DRAM
  for (genvar i = 0; i < NumRegions; i++) begin : gRegion
    adrDec #(
      .PaBits (PaBits)
    ) u_adrDec (
      .addr   (addr),
      .base   (RegionBase[i]),
      .range  (RegionRange[i]),
      .perm   (RegionPerm[i]),
      .sizes  (RegionSizes[i]),
      .access (access),
      .sel    (hselRegions[i])
    );
  end

  // The regions never overlap, so the vector is one-hot or all zero
  // An all zero vector is what the checker turns into an access fault

endmodule

// File: source/adrDec.sv
module adrDec #(
  parameter int PaBits = 32
) (
  input  logic [PaBits-1:0] addr,
  input  logic [31:0]       base,
  input  logic [31:0]       range,
  input  logic [2:0]        perm,
  input  logic [3:0]        sizes,
  input  pmaPkg::pmaAccessT access,
  output logic              sel
);
  import pmaPkg::*;

  logic [PaBits-1:0] baseWide;
  logic [PaBits-1:0] rangeWide;
  logic              addrMatch;
  logic              anyKind;
  logic              kindOk;
  logic              sizeOk;

  ////////////////////////////////////////////////////////////////////////////
  // Address match
  ////////////////////////////////////////////////////////////////////////////

  // The map is 32 bits wide, zero extension puts zeros above bit 31
  assign baseWide  = PaBits'(base);
  assign rangeWide = PaBits'(range);

  // Inverting the range keeps every bit above the region offset in the compare
  // Bits above 31 are compared against zero, so a high address bit never matches
  assign addrMatch = (addr & ~rangeWide) == baseWide;

  ////////////////////////////////////////////////////////////////////////////
  // Access kind and size
  ////////////////////////////////////////////////////////////////////////////

  assign anyKind = access.read | access.write | access.execute | access.atomic;

  // An atomic is a read-modify-write, so it needs both read and write rights
  // Whether the region allows atomics at all is decided in the checker
  assign kindOk = (!(access.read | access.atomic) || perm[PermRead]) &&
                  (!(access.write | access.atomic) || perm[PermWrite]) &&
                  (!access.execute || perm[PermExec]);

  // Reserved size codes never select a region
  assign sizeOk = (access.size < 3'(NumSizeCodes)) && sizes[access.size[1:0]];

  // No strobe means no access, and an idle bus selects nothing
  assign sel = anyKind && addrMatch && kindOk && sizeOk;

endmodule

// File: source/pmaPkg.sv
package pmaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Access, attribute and fault types
  ////////////////////////////////////////////////////////////////////////////

  // One memory access as seen by the checker
  // Size codes are 0 byte, 1 half, 2 word and 3 double, the rest are reserved
  typedef struct packed {
    logic       read;
    logic       write;
    logic       execute;
    logic       atomic;
    logic [2:0] size;
  } pmaAccessT;

  // Attributes of the selected region are all zero when nothing is selected
  typedef struct packed {
    logic cacheable;
    logic idempotent;
    logic atomicAllowed;
  } pmaAttrT;

  // Access fault kinds as reported to the trap unit
  typedef struct packed {
    logic instrFault;
    logic loadFault;
    logic storeFault;
  } pmaFaultT;

  ////////////////////////////////////////////////////////////////////////////
  // Region indices and encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumRegions    = 6;
  localparam int RegionPlic    = 0;
  localparam int RegionUart    = 1;
  localparam int RegionGpio    = 2;
  localparam int RegionClint   = 3;
  localparam int RegionDram    = 4;
  localparam int RegionBootRom = 5;

  // Bit positions inside a permission mask
  localparam int PermRead  = 2;
  localparam int PermWrite = 1;
  localparam int PermExec  = 0;

  localparam logic [2:0] PermRw  = 3'b110;
  localparam logic [2:0] PermRx  = 3'b101;
  localparam logic [2:0] PermRwx = 3'b111;

  // A size mask has one bit per size code, bit 0 is byte and bit 3 is double
  localparam int NumSizeCodes = 4;

  localparam logic [3:0] SizesAll        = 4'b1111;
  localparam logic [3:0] SizesWordDouble = 4'b1100;
  localparam logic [3:0] SizesWord       = 4'b0100;
  localparam logic [3:0] SizesByte       = 4'b0001;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed memory map in region index order
  ////////////////////////////////////////////////////////////////////////////

  // Every region is a power of two in size and aligned to its size
  localparam logic [31:0] RegionBase [NumRegions] = '{
    32'h0C00_0000, 32'h1000_0000, 32'h1006_0000,
    32'h0200_0000, 32'h8000_0000, 32'h0000_1000
  };

  // Range is the region size minus one, so it also acts as the offset mask
  localparam logic [31:0] RegionRange [NumRegions] = '{
    32'h03FF_FFFF, 32'h0000_0007, 32'h0000_00FF,
    32'h0000_FFFF, 32'h07FF_FFFF, 32'h0000_0FFF
  };

  localparam logic [2:0] RegionPerm [NumRegions] = '{
    PermRw, PermRw, PermRw, PermRw, PermRwx, PermRx
  };

  localparam logic [3:0] RegionSizes [NumRegions] = '{
    SizesWord, SizesByte, SizesWord, SizesWordDouble, SizesAll, SizesAll
  };

endpackage
